// ==== logic/frame_mux_pkg.sv ====
`default_nettype none

package frame_mux_pkg;

  // Stream payload
  localparam int DATA_W = 8; // One byte per beat

  // Per-port frame FIFO
  localparam int ADDR_W = 4; // 16 beats of storage

  // Arbiter
  localparam int NUM_PORTS = 2;
  localparam int PORT_W = 1; // Width of m_tid

  // tuser on a last beat that marks the frame bad
  localparam logic BAD_FRAME_USER = 1'b1;

endpackage

`default_nettype wire

// ==== logic/axis_frame_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_frame_fifo (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [frame_mux_pkg::DATA_W-1:0] s_tdata,
  input  logic                             s_tvalid,
  output logic                             s_tready,
  input  logic                             s_tlast,
  input  logic                             s_tuser,
  output logic [frame_mux_pkg::DATA_W-1:0] m_tdata,
  output logic                             m_tvalid,
  input  logic                             m_tready,
  output logic                             m_tlast,
  output logic                             overflow,
  output logic                             bad_frame,
  output logic                             good_frame
);
  import frame_mux_pkg::*;

  // Pointers carry one extra wrap bit
  logic [ADDR_W:0] wr_ptr;      // Committed, end of last good frame
  logic [ADDR_W:0] wr_ptr_next;
  logic [ADDR_W:0] wr_ptr_cur;  // Tentative, frame in progress
  logic [ADDR_W:0] wr_ptr_cur_next;
  logic [ADDR_W:0] rd_ptr;
  logic [ADDR_W:0] rd_ptr_next;

  logic [DATA_W:0] mem [2**ADDR_W]; // {tlast, tdata}

  logic [DATA_W:0] rd_data;
  logic            rd_valid;
  logic            rd_valid_next;
  logic [DATA_W:0] out_data;
  logic            out_valid;
  logic            out_valid_next;

  logic ready_reg;
  logic full_cur;
  logic empty;
  logic wr_en;
  logic rd_en;
  logic out_load;

  logic drop_frame;
  logic drop_frame_next;
  logic overflow_next;
  logic bad_frame_next;
  logic good_frame_next;

  // Full as seen by the writer, including the partial frame
  assign full_cur = (wr_ptr_cur[ADDR_W] != rd_ptr[ADDR_W]) &&
                    (wr_ptr_cur[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
  assign empty = (wr_ptr == rd_ptr); // Only committed beats count

  assign s_tready = ready_reg; // Never stalls, drops instead

  assign m_tdata  = out_data[DATA_W-1:0];
  assign m_tlast  = out_data[DATA_W];
  assign m_tvalid = out_valid;

  always_comb begin
    wr_en           = 1'b0;
    wr_ptr_next     = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    drop_frame_next = drop_frame;
    overflow_next   = 1'b0;
    bad_frame_next  = 1'b0;
    good_frame_next = 1'b0;
    if (s_tvalid && ready_reg) begin
      if (full_cur || drop_frame) begin
        // Swallow the rest of a frame that did not fit
        drop_frame_next = 1'b1;
        if (s_tlast) begin
          wr_ptr_cur_next = wr_ptr;
          drop_frame_next = 1'b0;
          overflow_next   = 1'b1;
        end
      end else begin
        wr_en           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s_tlast) begin
          if (s_tuser == BAD_FRAME_USER) begin
            wr_ptr_cur_next = wr_ptr; // Rewind
            bad_frame_next  = 1'b1;
          end else begin
            wr_ptr_next     = wr_ptr_cur + 1'b1; // Publish frame
            good_frame_next = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_reg  <= 1'b0;
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      drop_frame <= 1'b0;
      overflow   <= 1'b0;
      bad_frame  <= 1'b0;
      good_frame <= 1'b0;
    end else begin
      ready_reg  <= 1'b1;
      wr_ptr     <= wr_ptr_next;
      wr_ptr_cur <= wr_ptr_cur_next;
      drop_frame <= drop_frame_next;
      overflow   <= overflow_next;
      bad_frame  <= bad_frame_next;
      good_frame <= good_frame_next;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_cur[ADDR_W-1:0]] <= {s_tlast, s_tdata};
    end
  end

  // Read side, memory read register then output register
  always_comb begin
    out_load      = m_tready || !out_valid;
    rd_en         = 1'b0;
    rd_ptr_next   = rd_ptr;
    rd_valid_next = rd_valid;
    if (out_load || !rd_valid) begin
      if (!empty) begin
        rd_en         = 1'b1;
        rd_valid_next = 1'b1;
        rd_ptr_next   = rd_ptr + 1'b1;
      end else begin
        rd_valid_next = 1'b0;
      end
    end
    out_valid_next = out_load ? rd_valid : out_valid; // Hold under back-pressure
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr    <= '0;
      rd_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      rd_ptr    <= rd_ptr_next;
      rd_valid  <= rd_valid_next;
      out_valid <= out_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_ptr[ADDR_W-1:0]];
    end
    if (out_load) begin
      out_data <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/frame_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_arbiter (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [frame_mux_pkg::DATA_W-1:0] f0_tdata,
  input  logic [frame_mux_pkg::DATA_W-1:0] f1_tdata,
  input  logic                             f0_tvalid,
  input  logic                             f1_tvalid,
  input  logic                             f0_tlast,
  input  logic                             f1_tlast,
  output logic                             f0_tready,
  output logic                             f1_tready,
  output logic [frame_mux_pkg::DATA_W-1:0] m_tdata,
  output logic                             m_tvalid,
  output logic                             m_tlast,
  output logic [frame_mux_pkg::PORT_W-1:0] m_tid,
  input  logic                             m_tready
);
  import frame_mux_pkg::*;

  logic [PORT_W-1:0]    grant;    // Locked port while busy
  logic [PORT_W-1:0]    prio;     // Port served first when idle
  logic [PORT_W-1:0]    prio_alt;
  logic [PORT_W-1:0]    sel;
  logic [PORT_W-1:0]    sel_other;
  logic                 busy;
  logic [NUM_PORTS-1:0] valid_vec;

  assign valid_vec = {f1_tvalid, f0_tvalid};
  assign prio_alt  = PORT_W'((int'(prio) + 1) % NUM_PORTS);
  assign sel_other = PORT_W'((int'(sel) + 1) % NUM_PORTS);

  // Port choice, fixed while a frame is in progress
  always_comb begin
    if (busy) begin
      sel = grant;
    end else if (valid_vec[prio]) begin
      sel = prio;
    end else if (valid_vec[prio_alt]) begin
      sel = prio_alt;
    end else begin
      sel = prio;
    end
  end

  always_comb begin
    m_tdata  = f0_tdata;
    m_tvalid = f0_tvalid;
    m_tlast  = f0_tlast;
    if (sel != '0) begin
      m_tdata  = f1_tdata;
      m_tvalid = f1_tvalid;
      m_tlast  = f1_tlast;
    end
  end

  assign m_tid     = sel;
  assign f0_tready = m_tready && (sel == '0);
  assign f1_tready = m_tready && (sel != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      grant <= '0;
      prio  <= '0;
    end else begin
      if (m_tvalid && m_tready && m_tlast) begin
        busy <= 1'b0;
        prio <= sel_other; // Round robin
      end else if (!busy && m_tvalid) begin
        // Lock as soon as a beat is offered so it stays stable
        busy  <= 1'b1;
        grant <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/frame_mux_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_mux_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [frame_mux_pkg::DATA_W-1:0] s0_tdata,
  input  logic                             s0_tvalid,
  output logic                             s0_tready,
  input  logic                             s0_tlast,
  input  logic                             s0_tuser,
  input  logic [frame_mux_pkg::DATA_W-1:0] s1_tdata,
  input  logic                             s1_tvalid,
  output logic                             s1_tready,
  input  logic                             s1_tlast,
  input  logic                             s1_tuser,
  output logic [frame_mux_pkg::DATA_W-1:0] m_tdata,
  output logic                             m_tvalid,
  input  logic                             m_tready,
  output logic                             m_tlast,
  output logic [frame_mux_pkg::PORT_W-1:0] m_tid,
  output logic                             overflow0,
  output logic                             overflow1,
  output logic                             bad_frame0,
  output logic                             bad_frame1,
  output logic                             good_frame0,
  output logic                             good_frame1
);
  import frame_mux_pkg::*;

  // FIFO to arbiter links
  logic [DATA_W-1:0] f0_tdata;
  logic              f0_tvalid;
  logic              f0_tready;
  logic              f0_tlast;
  logic [DATA_W-1:0] f1_tdata;
  logic              f1_tvalid;
  logic              f1_tready;
  logic              f1_tlast;

  axis_frame_fifo fifo0 (
    .clk        (clk),
    .rst        (rst),
    .s_tdata    (s0_tdata),
    .s_tvalid   (s0_tvalid),
    .s_tready   (s0_tready),
    .s_tlast    (s0_tlast),
    .s_tuser    (s0_tuser),
    .m_tdata    (f0_tdata),
    .m_tvalid   (f0_tvalid),
    .m_tready   (f0_tready),
    .m_tlast    (f0_tlast),
    .overflow   (overflow0),
    .bad_frame  (bad_frame0),
    .good_frame (good_frame0)
  );

  axis_frame_fifo fifo1 (
    .clk        (clk),
    .rst        (rst),
    .s_tdata    (s1_tdata),
    .s_tvalid   (s1_tvalid),
    .s_tready   (s1_tready),
    .s_tlast    (s1_tlast),
    .s_tuser    (s1_tuser),
    .m_tdata    (f1_tdata),
    .m_tvalid   (f1_tvalid),
    .m_tready   (f1_tready),
    .m_tlast    (f1_tlast),
    .overflow   (overflow1),
    .bad_frame  (bad_frame1),
    .good_frame (good_frame1)
  );

  frame_arbiter arb0 (
    .clk       (clk),
    .rst       (rst),
    .f0_tdata  (f0_tdata),
    .f1_tdata  (f1_tdata),
    .f0_tvalid (f0_tvalid),
    .f1_tvalid (f1_tvalid),
    .f0_tlast  (f0_tlast),
    .f1_tlast  (f1_tlast),
    .f0_tready (f0_tready),
    .f1_tready (f1_tready),
    .m_tdata   (m_tdata),
    .m_tvalid  (m_tvalid),
    .m_tlast   (m_tlast),
    .m_tid     (m_tid),
    .m_tready  (m_tready)
  );

endmodule

`default_nettype wire

// ==== testbench/frame_mux_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_mux_assertions (
  input logic                             clk,
  input logic                             rst,
  input logic [frame_mux_pkg::DATA_W-1:0] m_tdata,
  input logic                             m_tvalid,
  input logic                             m_tready,
  input logic                             m_tlast,
  input logic [frame_mux_pkg::PORT_W-1:0] m_tid,
  input logic                             overflow0,
  input logic                             overflow1,
  input logic                             bad_frame0,
  input logic                             bad_frame1,
  input logic                             good_frame0,
  input logic                             good_frame1
);
  import frame_mux_pkg::*;

  logic [5:0]        status;
  logic              in_frame;  // Beat accepted, last not yet
  logic [PORT_W-1:0] frame_tid;
  int                fail_count = 0;

  assign status = {overflow1, overflow0, bad_frame1, bad_frame0, good_frame1, good_frame0};

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame  <= 1'b0;
      frame_tid <= '0;
    end else if (m_tvalid && m_tready) begin
      in_frame  <= !m_tlast;
      frame_tid <= m_tid;
    end
  end

  hold_under_backpressure: assert property (@(posedge clk) disable iff (rst)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast) && $stable(m_tid))
  else begin
    $error("output beat changed while stalled");
    fail_count++;
  end

  tid_fixed_in_frame: assert property (@(posedge clk) disable iff (rst)
    in_frame && m_tvalid |-> m_tid == frame_tid)
  else begin
    $error("m_tid changed inside a frame");
    fail_count++;
  end

  quiet_after_reset: assert property (@(posedge clk) rst |=> !m_tvalid && status == '0)
  else begin
    $error("output valid or status high right after reset");
    fail_count++;
  end

  // Each status flag is a single-cycle pulse
  status_one_cycle: assert property (@(posedge clk) disable iff (rst)
    (status & $past(status)) == '0)
  else begin
    $error("status output held for more than one cycle");
    fail_count++;
  end

endmodule

bind frame_mux_top frame_mux_assertions asrt0 (
  .clk         (clk),
  .rst         (rst),
  .m_tdata     (m_tdata),
  .m_tvalid    (m_tvalid),
  .m_tready    (m_tready),
  .m_tlast     (m_tlast),
  .m_tid       (m_tid),
  .overflow0   (overflow0),
  .overflow1   (overflow1),
  .bad_frame0  (bad_frame0),
  .bad_frame1  (bad_frame1),
  .good_frame0 (good_frame0),
  .good_frame1 (good_frame1)
);

`default_nettype wire

// ==== testbench/frame_mux_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_mux_tb;
  import frame_mux_pkg::*;

  localparam int FIFO_DEPTH   = 2**ADDR_W;
  localparam int WAIT_TIMEOUT = 5000;
  localparam int READY_LOW    = 0;
  localparam int READY_RANDOM = 1;

  logic clk, rst;
  logic [DATA_W-1:0] s0_tdata, s1_tdata, m_tdata;
  logic s0_tvalid, s0_tready, s0_tlast, s0_tuser;
  logic s1_tvalid, s1_tready, s1_tlast, s1_tuser;
  logic m_tvalid, m_tready, m_tlast;
  logic [PORT_W-1:0] m_tid;
  logic overflow0, overflow1, bad_frame0, bad_frame1, good_frame0, good_frame1;

  string             test_name;
  int                ready_mode;
  bit                ready_on;    // Readies checked from here on
  bit                frame_open;
  bit                have_last;
  logic [PORT_W-1:0] last_tid;
  logic [DATA_W:0]   exp0[$];     // {tlast, tdata}
  logic [DATA_W:0]   exp1[$];
  int used[NUM_PORTS];            // Model of stored beats per port
  int exp_good[NUM_PORTS], exp_bad[NUM_PORTS], exp_ovf[NUM_PORTS];
  int good_cnt[NUM_PORTS], bad_cnt[NUM_PORTS], ovf_cnt[NUM_PORTS];

  frame_mux_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("tests failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("error %s, %s: expected %0h, actual %0h", test_name, what, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_cond(input bit cond, input string msg);
    assert (cond) else begin
      $display("%s: %s", test_name, msg);
      stop_on_failure();
    end
  endtask

  task automatic drive_port(input int port, input logic [DATA_W-1:0] data,
                            input logic valid, input logic last, input logic user);
    if (port == 0) begin
      s0_tdata  = data;
      s0_tvalid = valid;
      s0_tlast  = last;
      s0_tuser  = user;
    end else begin
      s1_tdata  = data;
      s1_tvalid = valid;
      s1_tlast  = last;
      s1_tuser  = user;
    end
  endtask

  // Expected outcome is decided from the model's free space
  task automatic send_frame(input int port, input int len, input bit bad);
    logic [DATA_W-1:0] data;
    bit                fits;
    fits = (len <= FIFO_DEPTH - used[port]);
    if (!fits) exp_ovf[port]++;
    else if (bad) exp_bad[port]++;
    else begin
      exp_good[port]++;
      used[port] += len;
    end
    for (int i = 0; i < len; i++) begin
      data = DATA_W'($urandom);
      @(posedge clk);
      #1;
      drive_port(port, data, 1'b1, i == len - 1, bad && i == len - 1);
      if (fits && !bad && port == 0) exp0.push_back({i == len - 1, data});
      else if (fits && !bad) exp1.push_back({i == len - 1, data});
    end
    @(posedge clk);
    #1;
    drive_port(port, '0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic wait_for_space(input int port, input int len);
    int cycles;
    cycles = 0;
    while (FIFO_DEPTH - used[port] < len) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_TIMEOUT) begin
        $display("%s: port %0d never freed room for %0d beats", test_name, port, len);
        stop_on_failure();
      end
    end
  endtask

  task automatic run_traffic(input int port, input int frames, input bit with_bad);
    int len;
    for (int i = 0; i < frames; i++) begin
      len = 1 + int'($urandom % 8);
      wait_for_space(port, len);
      send_frame(port, len, with_bad && (i % 3 == 1));
      repeat ($urandom % 3) @(posedge clk);
    end
  endtask

  task automatic finish_test();
    int cycles;
    cycles = 0;
    while (exp0.size() != 0 || exp1.size() != 0 || m_tvalid) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_TIMEOUT) begin
        $display("%s: output did not drain within %0d cycles", test_name, WAIT_TIMEOUT);
        stop_on_failure();
      end
    end
    repeat (3) @(negedge clk); // Last status pulses
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_value($sformatf("good_frame%0d pulses", p), exp_good[p], good_cnt[p]);
      check_value($sformatf("bad_frame%0d pulses", p), exp_bad[p], bad_cnt[p]);
      check_value($sformatf("overflow%0d pulses", p), exp_ovf[p], ovf_cnt[p]);
    end
  endtask

  initial begin
    forever begin
      @(posedge clk);
      #1;
      m_tready = (ready_mode == READY_RANDOM) ? 1'($urandom) : 1'b0;
    end
  end

  // Output scoreboard and status counters
  always @(negedge clk) begin : monitor
    logic [DATA_W:0] beat;
    logic            other_valid;
    if (!rst) begin
      if (dut0.asrt0.fail_count != 0) begin
        $display("%s: a bound assertion failed", test_name);
        stop_on_failure();
      end
      if (ready_on) check_cond(s0_tready && s1_tready, "an input ready went low");
      good_cnt[0] += int'(good_frame0);
      good_cnt[1] += int'(good_frame1);
      bad_cnt[0]  += int'(bad_frame0);
      bad_cnt[1]  += int'(bad_frame1);
      ovf_cnt[0]  += int'(overflow0);
      ovf_cnt[1]  += int'(overflow1);
      if (m_tvalid && !frame_open) begin
        frame_open  = 1'b1; // Grant locks in this cycle
        other_valid = (m_tid == '0) ? dut0.f1_tvalid : dut0.f0_tvalid;
        if (have_last && m_tid == last_tid)
          check_cond(!other_valid, "same port served twice while the other waited");
      end
      if (m_tvalid && m_tready) begin
        if (m_tid == '0) begin
          check_cond(exp0.size() != 0, "output beat from port 0 that was never sent");
          beat = exp0.pop_front();
        end else begin
          check_cond(exp1.size() != 0, "output beat from port 1 that was never sent");
          beat = exp1.pop_front();
        end
        used[m_tid]--;
        check_value($sformatf("port %0d beat", m_tid), beat, {m_tlast, m_tdata});
        if (m_tlast) begin
          frame_open = 1'b0;
          have_last  = 1'b1;
          last_tid   = m_tid;
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h80e6_838d));
    rst        = 1'b1;
    m_tready   = 1'b0;
    ready_mode = READY_LOW;
    ready_on   = 1'b0;
    frame_open = 1'b0;
    have_last  = 1'b0;
    drive_port(0, '0, 1'b0, 1'b0, 1'b0);
    drive_port(1, '0, 1'b0, 1'b0, 1'b0);
    test_name = "reset";
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_value("m_tvalid", 0, m_tvalid);
    check_value("status outputs", 0, {overflow1, overflow0, bad_frame1, bad_frame0,
                                      good_frame1, good_frame0});
    check_value("input readies, first cycle", 0, {s1_tready, s0_tready});
    @(negedge clk);
    check_value("input readies, second cycle", 3, {s1_tready, s0_tready});
    ready_on = 1'b1;

    // Uneven frame counts so per-port pulse totals differ
    ready_mode = READY_RANDOM;
    test_name  = "good frames";
    fork
      run_traffic(0, 25, 1'b0);
      run_traffic(1, 20, 1'b0);
    join
    finish_test();

    test_name = "bad frames";
    fork
      run_traffic(0, 12, 1'b1);
      run_traffic(1, 9, 1'b1);
    join
    finish_test();

    // Sizes chosen so prefetched beats cannot change the outcome
    test_name  = "overflow";
    ready_mode = READY_LOW;
    for (int p = 0; p < NUM_PORTS; p++) begin
      send_frame(p, 8, 1'b0);
      send_frame(p, 12, 1'b0);
      send_frame(p, 4, 1'b0);
      if (p == 1) send_frame(p, 7, 1'b0);
    end
    ready_mode = READY_RANDOM;
    finish_test();

    test_name = "after overflow";
    fork
      run_traffic(0, 10, 1'b0);
      run_traffic(1, 10, 1'b0);
    join
    finish_test();

    if (dut0.asrt0.fail_count != 0) begin
      $display("%0d bound assertion failures", dut0.asrt0.fail_count);
      stop_on_failure();
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== frame_mux.f ====
logic/frame_mux_pkg.sv
logic/axis_frame_fifo.sv
logic/frame_arbiter.sv
logic/frame_mux_top.sv
testbench/frame_mux_assertions.sv
testbench/frame_mux_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f frame_mux.f \
  --top-module frame_mux_tb -o frame_mux_sim > build.log 2>&1 ||
  { cat build.log; echo "build failed"; exit 1; }
./obj_dir/frame_mux_sim +verilator+error+limit+1000 > sim.log 2>&1 ||
  echo "simulation exited with an error status" >> sim.log
cat sim.log
grep -q "all tests passed" sim.log && ! grep -q "tests failed" sim.log &&
  echo "PASS" || { echo "FAIL"; exit 1; }
